// File: cache_pkg.sv
// 16 sets of 64-byte lines on a 32-bit byte address, 64-bit cpu words; no coherence or uncached space
package cache_pkg;

  // address and word widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 64;
  localparam int LINE_W = 512;
  // byte lanes in one cpu word
  localparam int WORD_BYTES = WORD_W / 8;

  // direct-mapped geometry
  localparam int NUM_SETS = 16;
  // byte offset inside a line
  localparam int OFFSET_W = $clog2(LINE_W / 8);
  localparam int INDEX_W = $clog2(NUM_SETS);
  // whatever is left above index and offset
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
  // which 64-bit word of the line
  localparam int WORD_SEL_W = $clog2(LINE_W / WORD_W);

  // stored tag and one whole line
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [LINE_W-1:0] line_t;

  // one cpu load or store
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    // 1 for store
    logic we;
    logic [WORD_W-1:0] wdata;
    // one bit per byte lane
    logic [WORD_BYTES-1:0] wstrb;
  } cpu_req_t;

  // controller to line transfer unit
  typedef struct packed {
    // 0 read, 1 write
    logic op;
    // line aligned
    logic [ADDR_W-1:0] addr;
    line_t wline;
  } line_req_t;

  // memory bus request, always one full line
  typedef struct packed {
    // 0 read, 1 write
    logic op;
    // low OFFSET_W bits are zero
    logic [ADDR_W-1:0] addr;
    line_t wdata;
  } bus_req_t;

endpackage

// File: cache_ram.sv
// registered read, old data returned on a same-index read and write; contents are not reset
`timescale 1ns/10ps

module cache_ram #(
  // payload type, tag word or whole line
  parameter type T = cache_pkg::line_t
) (
  input  logic                          clk,
  // read port, data one edge later
  input  logic [cache_pkg::INDEX_W-1:0] i_raddr,
  output T                              o_rdata,
  // write port
  input  logic                          i_we,
  input  logic [cache_pkg::INDEX_W-1:0] i_waddr,
  input  T                              i_wdata
);

  // one entry per set
  T mem [cache_pkg::NUM_SETS];

  // synchronous write
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // registered read, sampled every edge
  always_ff @(posedge clk) begin
    o_rdata <= mem[i_raddr];
  end

endmodule

// File: cache_rw.sv
// one 512-bit line per bus handshake; the caller must not start while a transfer is pending
`timescale 1ns/10ps

module cache_rw (
  input  logic                 clk,
  input  logic                 rst,
  // controller side
  input  logic                 i_start,
  input  cache_pkg::line_req_t i_line_req,
  output logic                 o_done,
  output cache_pkg::line_t     o_rline,
  // memory bus side
  output logic                 o_bus_valid,
  output cache_pkg::bus_req_t  o_bus_req,
  input  logic                 i_bus_ready,
  input  cache_pkg::line_t     i_bus_rdata
);

  // transfer completes on this cycle
  logic bus_hs;

  assign bus_hs = o_bus_valid & i_bus_ready;

  // valid and done sequencing
  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_valid <= 1'b0;
      o_done      <= 1'b0;
    end else begin
      // done is one edge behind the handshake
      o_done <= bus_hs;
      if (bus_hs) begin
        o_bus_valid <= 1'b0;
      end else if (i_start) begin
        o_bus_valid <= 1'b1;
      end
    end
  end

  // request latched once, held through any bus stall
  always_ff @(posedge clk) begin
    if (i_start) begin
      o_bus_req.op    <= i_line_req.op;
      o_bus_req.addr  <= i_line_req.addr;
      o_bus_req.wdata <= i_line_req.wline;
    end
    // read line arrives with ready
    if (bus_hs) begin
      o_rline <= i_bus_rdata;
    end
  end

  // controller waits for done before the next start
  a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    i_start |-> !o_bus_valid && !o_done);

  // bus request frozen while the slave stalls
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    o_bus_valid && !i_bus_ready |=> o_bus_valid && $stable(o_bus_req));

  // controller hands over line aligned addresses only
  a_addr_aligned: assert property (@(posedge clk) disable iff (rst)
    o_bus_valid |-> o_bus_req.addr[cache_pkg::OFFSET_W-1:0] == '0);

endmodule

// File: cache_ctrl.sv
// direct-mapped write-back write-allocate; one cpu request at a time, next only after done
`timescale 1ns/10ps

module cache_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  // cpu port
  input  logic                          i_cpu_valid,
  input  cache_pkg::cpu_req_t           i_cpu_req,
  output logic                          o_cpu_done,
  output logic [cache_pkg::WORD_W-1:0]  o_cpu_rdata,
  // both arrays share read and write index
  output logic [cache_pkg::INDEX_W-1:0] o_raddr,
  output logic [cache_pkg::INDEX_W-1:0] o_waddr,
  // tag array
  input  cache_pkg::tag_t               i_tag_rdata,
  output logic                          o_tag_we,
  output cache_pkg::tag_t               o_tag_wdata,
  // data array
  input  cache_pkg::line_t              i_data_rdata,
  output logic                          o_data_we,
  output cache_pkg::line_t              o_data_wdata,
  // line transfer unit
  output logic                          o_rw_start,
  output cache_pkg::line_req_t          o_rw_req,
  input  logic                          i_rw_done,
  input  cache_pkg::line_t              i_rw_rline
);

  // lookup waits out the array read, resp compares and answers
  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_WBACK,
    S_REFILL,
    S_RESP
  } state_t;

  state_t state;

  // accepted request
  cache_pkg::cpu_req_t req_q;
  // per set status
  logic [cache_pkg::NUM_SETS-1:0] valid_q;
  logic [cache_pkg::NUM_SETS-1:0] dirty_q;

  // address fields of the held request
  logic [cache_pkg::INDEX_W-1:0]    req_idx;
  cache_pkg::tag_t                  req_tag;
  logic [cache_pkg::WORD_SEL_W-1:0] word_sel;

  logic                         hit;
  logic                         wb_needed;
  logic [cache_pkg::WORD_W-1:0] old_word;
  logic [cache_pkg::WORD_W-1:0] new_word;
  cache_pkg::line_t             merged_line;
  cache_pkg::line_req_t         refill_req;
  cache_pkg::line_req_t         victim_req;

  assign req_idx  = req_q.addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  assign req_tag  = req_q.addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign word_sel = req_q.addr[cache_pkg::OFFSET_W-1 -: cache_pkg::WORD_SEL_W];

  // arrays always look at the current set
  assign o_raddr = req_idx;
  assign o_waddr = req_idx;

  // valid only in S_RESP, when array outputs match req_q
  assign hit       = valid_q[req_idx] && (i_tag_rdata == req_tag);
  assign wb_needed = valid_q[req_idx] && dirty_q[req_idx];

  // byte strobe merge into the selected word
  always_comb begin
    old_word = i_data_rdata[word_sel*cache_pkg::WORD_W +: cache_pkg::WORD_W];
    new_word = old_word;
    if (req_q.we) begin
      for (int b = 0; b < cache_pkg::WORD_BYTES; b++) begin
        if (req_q.wstrb[b]) begin
          new_word[b*8 +: 8] = req_q.wdata[b*8 +: 8];
        end
      end
    end
    merged_line = i_data_rdata;
    merged_line[word_sel*cache_pkg::WORD_W +: cache_pkg::WORD_W] = new_word;
  end

  // refill reads the new line, wline unused
  assign refill_req.op    = 1'b0;
  assign refill_req.addr  = {req_tag, req_idx, {cache_pkg::OFFSET_W{1'b0}}};
  assign refill_req.wline = '0;

  // victim goes back to its old tag's address
  assign victim_req.op    = 1'b1;
  assign victim_req.addr  = {i_tag_rdata, req_idx, {cache_pkg::OFFSET_W{1'b0}}};
  assign victim_req.wline = i_data_rdata;

  // refill writes raw line and tag, a store hit writes merged line
  assign o_tag_we     = (state == S_REFILL) && i_rw_done;
  assign o_tag_wdata  = req_tag;
  assign o_data_we    = o_tag_we || ((state == S_RESP) && hit && req_q.we);
  assign o_data_wdata = (state == S_REFILL) ? i_rw_rline : merged_line;

  // control FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      valid_q    <= '0;
      dirty_q    <= '0;
      o_cpu_done <= 1'b0;
      o_rw_start <= 1'b0;
    end else begin
      // both strobes last one cycle
      o_cpu_done <= 1'b0;
      o_rw_start <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_cpu_valid) begin
            state <= S_LOOKUP;
          end
        end
        // array read in flight
        S_LOOKUP: begin
          state <= S_RESP;
        end
        S_RESP: begin
          if (hit) begin
            o_cpu_done <= 1'b1;
            if (req_q.we) begin
              dirty_q[req_idx] <= 1'b1;
            end
            state <= S_IDLE;
          end else begin
            o_rw_start <= 1'b1;
            state      <= wb_needed ? S_WBACK : S_REFILL;
          end
        end
        // victim written, now fetch the new line
        S_WBACK: begin
          if (i_rw_done) begin
            o_rw_start <= 1'b1;
            state      <= S_REFILL;
          end
        end
        // line installed clean, re-read it and answer as a hit
        S_REFILL: begin
          if (i_rw_done) begin
            valid_q[req_idx] <= 1'b1;
            dirty_q[req_idx] <= 1'b0;
            state            <= S_LOOKUP;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // request, response word and line request payloads
  always_ff @(posedge clk) begin
    if ((state == S_IDLE) && i_cpu_valid) begin
      req_q <= i_cpu_req;
    end
    // store returns the merged word too
    if ((state == S_RESP) && hit) begin
      o_cpu_rdata <= new_word;
    end
    if ((state == S_RESP) && !hit) begin
      o_rw_req <= wb_needed ? victim_req : refill_req;
    end
    if ((state == S_WBACK) && i_rw_done) begin
      o_rw_req <= refill_req;
    end
  end

  // cpu holds off until done
  a_one_request: assert property (@(posedge clk) disable iff (rst)
    i_cpu_valid |-> state == S_IDLE);

endmodule

// File: cache_top.sv
// data cache for one 64-bit load/store port; memory side moves whole 64-byte lines only
`timescale 1ns/10ps

module cache_top (
  input  logic                         clk,
  input  logic                         rst,
  // cpu port
  input  logic                         i_cpu_valid,
  input  cache_pkg::cpu_req_t          i_cpu_req,
  output logic                         o_cpu_done,
  output logic [cache_pkg::WORD_W-1:0] o_cpu_rdata,
  // memory bus
  output logic                         o_bus_valid,
  output cache_pkg::bus_req_t          o_bus_req,
  input  logic                         i_bus_ready,
  input  cache_pkg::line_t             i_bus_rdata
);

  // array ports
  logic [cache_pkg::INDEX_W-1:0] raddr;
  logic [cache_pkg::INDEX_W-1:0] waddr;
  cache_pkg::tag_t               tag_rdata;
  logic                          tag_we;
  cache_pkg::tag_t               tag_wdata;
  cache_pkg::line_t              data_rdata;
  logic                          data_we;
  cache_pkg::line_t              data_wdata;

  // controller to line transfer unit
  logic                 rw_start;
  cache_pkg::line_req_t rw_req;
  logic                 rw_done;
  cache_pkg::line_t     rw_rline;

  cache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .i_cpu_valid  (i_cpu_valid),
    .i_cpu_req    (i_cpu_req),
    .o_cpu_done   (o_cpu_done),
    .o_cpu_rdata  (o_cpu_rdata),
    .o_raddr      (raddr),
    .o_waddr      (waddr),
    .i_tag_rdata  (tag_rdata),
    .o_tag_we     (tag_we),
    .o_tag_wdata  (tag_wdata),
    .i_data_rdata (data_rdata),
    .o_data_we    (data_we),
    .o_data_wdata (data_wdata),
    .o_rw_start   (rw_start),
    .o_rw_req     (rw_req),
    .i_rw_done    (rw_done),
    .i_rw_rline   (rw_rline)
  );

  // tag words
  cache_ram #(
    .T (cache_pkg::tag_t)
  ) u_tag_ram (
    .clk     (clk),
    .i_raddr (raddr),
    .o_rdata (tag_rdata),
    .i_we    (tag_we),
    .i_waddr (waddr),
    .i_wdata (tag_wdata)
  );

  // data lines
  cache_ram #(
    .T (cache_pkg::line_t)
  ) u_data_ram (
    .clk     (clk),
    .i_raddr (raddr),
    .o_rdata (data_rdata),
    .i_we    (data_we),
    .i_waddr (waddr),
    .i_wdata (data_wdata)
  );

  cache_rw u_rw (
    .clk         (clk),
    .rst         (rst),
    .i_start     (rw_start),
    .i_line_req  (rw_req),
    .o_done      (rw_done),
    .o_rline     (rw_rline),
    .o_bus_valid (o_bus_valid),
    .o_bus_req   (o_bus_req),
    .i_bus_ready (i_bus_ready),
    .i_bus_rdata (i_bus_rdata)
  );

endmodule

// File: tb_cache_top.sv
// cpu traffic limited to 4 tags by 16 sets by 8 words; bus slave answers each line in one handshake
`timescale 1ns/10ps

module tb_cache_top;

  // 4 tags over 16 sets of 64-byte lines
  localparam int LINE_BYTES   = cache_pkg::LINE_W / 8;
  localparam int MEM_LINES    = 4 * cache_pkg::NUM_SETS;
  localparam int MEM_BYTES    = MEM_LINES * LINE_BYTES;
  localparam int NUM_ACCESSES = 2000;
  localparam int DONE_TIMEOUT = 400;
  // inputs change this long after the rising edge
  localparam int DRIVE_DLY    = 2;

  logic                         clk;
  logic                         rst;
  logic                         cpu_valid;
  cache_pkg::cpu_req_t          cpu_req;
  logic                         cpu_done;
  logic [cache_pkg::WORD_W-1:0] cpu_rdata;
  logic                         bus_valid;
  cache_pkg::bus_req_t          bus_req;
  logic                         bus_ready;
  cache_pkg::line_t             bus_rdata;

  // cpu view of memory, always up to date
  logic [7:0]                     ref_mem [MEM_BYTES];
  // backing store behind the bus, stale for dirty lines
  cache_pkg::line_t               bus_mem [MEM_LINES];
  // per set tag model
  logic [cache_pkg::NUM_SETS-1:0] valid_m;
  logic [cache_pkg::NUM_SETS-1:0] dirty_m;
  logic [1:0]                     tag_m [cache_pkg::NUM_SETS];
  // completed bus transfers since the last cpu access
  cache_pkg::bus_req_t            seen_q [$];
  logic [31:0]                    lcg_state;

  cache_top DUT (
    .clk         (clk),
    .rst         (rst),
    .i_cpu_valid (cpu_valid),
    .i_cpu_req   (cpu_req),
    .o_cpu_done  (cpu_done),
    .o_cpu_rdata (cpu_rdata),
    .o_bus_valid (bus_valid),
    .o_bus_req   (bus_req),
    .i_bus_ready (bus_ready),
    .i_bus_rdata (bus_rdata)
  );

  // 40 ns period
  initial clk = 1'b0;
  always #20 clk = ~clk;

  // low state bits have short periods, so the upper half lands in the low bits
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  // mixes line number into byte offset, all 12 address bits matter
  function automatic logic [7:0] fill_byte(input int unsigned a);
    return 8'(a) ^ 8'((a >> 6) * 37);
  endfunction

  // assemble one line from the byte model
  function automatic cache_pkg::line_t ref_line(input int unsigned line);
    cache_pkg::line_t l;
    for (int b = 0; b < LINE_BYTES; b++) begin
      l[b*8 +: 8] = ref_mem[line * LINE_BYTES + b];
    end
    return l;
  endfunction

  task automatic check_equal(input cache_pkg::line_t got, input cache_pkg::line_t exp,
                             input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("Errors found");
    $fatal(1, "simulation stuck");
  endtask

  // bus slave, 0 to 5 stall cycles then a one-cycle ready
  initial begin : bus_slave
    cache_pkg::bus_req_t held;
    int                  stalls;
    int unsigned         line;
    bus_ready = 1'b0;
    bus_rdata = '0;
    forever begin
      @(posedge clk);
      #(DRIVE_DLY);
      if (!rst && bus_valid) begin
        held   = bus_req;
        stalls = lcg_next() % 6;
        line   = 32'(held.addr[11:6]);
        for (int s = 0; s < stalls; s++) begin
          @(posedge clk);
          #(DRIVE_DLY);
          check_equal(cache_pkg::line_t'(bus_valid), cache_pkg::line_t'(1'b1),
                      "bus valid dropped during stall");
          check_equal(cache_pkg::line_t'(bus_req.op), cache_pkg::line_t'(held.op),
                      "bus op changed during stall");
          check_equal(cache_pkg::line_t'(bus_req.addr), cache_pkg::line_t'(held.addr),
                      "bus address changed during stall");
          check_equal(bus_req.wdata, held.wdata, "bus write data changed during stall");
        end
        bus_ready = 1'b1;
        bus_rdata = held.op ? '0 : bus_mem[line];
        // handshake edge
        @(posedge clk);
        #(DRIVE_DLY);
        bus_ready = 1'b0;
        if (held.op) begin
          bus_mem[line] = held.wdata;
        end
        seen_q.push_back(held);
        // one transfer per handshake
        check_equal(cache_pkg::line_t'(bus_valid), '0, "bus valid high after handshake");
      end
    end
  end

  initial begin : cpu_driver
    cache_pkg::cpu_req_t    req;
    logic [1:0]             tag;
    logic [3:0]             idx;
    logic [2:0]             wsel;
    logic [31:0]            r_hi;
    logic [31:0]            r_lo;
    int unsigned            base;
    int unsigned            new_line;
    int unsigned            old_line;
    logic [63:0]            old_word;
    logic [63:0]            exp_word;
    logic                   hit_p;
    logic                   wb_p;
    cache_pkg::line_t       victim;
    cache_pkg::bus_req_t    last;
    int                     edges;
    cpu_valid = 1'b0;
    cpu_req   = '0;
    rst       = 1'b1;
    lcg_state = 32'd59272;
    valid_m   = '0;
    dirty_m   = '0;
    for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
      tag_m[s] = '0;
    end
    // same pattern on both sides of the cache
    for (int a = 0; a < MEM_BYTES; a++) begin
      ref_mem[a] = fill_byte(a);
      bus_mem[a / LINE_BYTES][(a % LINE_BYTES) * 8 +: 8] = fill_byte(a);
    end
    repeat (4) @(posedge clk);
    #(DRIVE_DLY);
    rst = 1'b0;
    check_equal(cache_pkg::line_t'(cpu_done), '0, "cpu done after reset");
    check_equal(cache_pkg::line_t'(bus_valid), '0, "bus valid after reset");

    for (int n = 0; n < NUM_ACCESSES; n++) begin
      tag       = 2'(lcg_next());
      idx       = 4'(lcg_next());
      wsel      = 3'(lcg_next());
      req.we    = 1'(lcg_next());
      req.wstrb = 8'(lcg_next());
      r_hi      = lcg_next();
      r_lo      = lcg_next();
      req.wdata = {r_hi, r_lo};
      req.addr  = {20'h0, tag, idx, wsel, 3'b000};

      // predict from the tag model before it changes
      base     = 32'({tag, idx, wsel, 3'b000});
      new_line = 32'({tag, idx});
      old_line = 32'({tag_m[idx], idx});
      hit_p    = valid_m[idx] && (tag_m[idx] == tag);
      wb_p     = !hit_p && valid_m[idx] && dirty_m[idx];
      victim   = ref_line(old_line);
      for (int b = 0; b < 8; b++) begin
        old_word[b*8 +: 8] = ref_mem[base + b];
      end
      exp_word = old_word;
      if (req.we) begin
        for (int b = 0; b < 8; b++) begin
          if (req.wstrb[b]) begin
            exp_word[b*8 +: 8] = req.wdata[b*8 +: 8];
            ref_mem[base + b]  = req.wdata[b*8 +: 8];
          end
        end
      end

      // one-cycle request strobe
      cpu_req   = req;
      cpu_valid = 1'b1;
      @(posedge clk);
      #(DRIVE_DLY);
      cpu_valid = 1'b0;
      edges     = 0;
      while (!cpu_done) begin
        @(posedge clk);
        #(DRIVE_DLY);
        edges++;
        if (edges > DONE_TIMEOUT) begin
          stop_on_timeout("cpu done");
        end
      end

      check_equal(cache_pkg::line_t'(cpu_rdata), cache_pkg::line_t'(exp_word),
                  "cpu word after merge");
      if (hit_p) begin
        check_equal(cache_pkg::line_t'(edges), cache_pkg::line_t'(2), "hit latency in edges");
        check_equal(cache_pkg::line_t'(seen_q.size()), '0, "bus transfers on a hit");
      end else begin
        check_equal(cache_pkg::line_t'(seen_q.size()), cache_pkg::line_t'(wb_p ? 2 : 1),
                    "bus transfers on a miss");
        // dirty victim goes out first
        if (wb_p) begin
          check_equal(cache_pkg::line_t'(seen_q[0].op), cache_pkg::line_t'(1'b1),
                      "write-back op");
          check_equal(cache_pkg::line_t'(seen_q[0].addr),
                      cache_pkg::line_t'(old_line * LINE_BYTES), "write-back address");
          check_equal(seen_q[0].wdata, victim, "write-back line");
        end
        last = seen_q[seen_q.size() - 1];
        check_equal(cache_pkg::line_t'(last.op), '0, "refill op");
        check_equal(cache_pkg::line_t'(last.addr), cache_pkg::line_t'(new_line * LINE_BYTES),
                    "refill address");
        valid_m[idx] = 1'b1;
        dirty_m[idx] = 1'b0;
        tag_m[idx]   = tag;
      end
      seen_q.delete();
      // any store dirties the line, empty strobe too
      if (req.we) begin
        dirty_m[idx] = 1'b1;
      end
    end

    $display("No errors");
    $finish;
  end

endmodule

// File: list.f
cache_pkg.sv
cache_ram.sv
cache_rw.sv
cache_ctrl.sv
cache_top.sv
tb_cache_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cache_top -f list.f
# the run may stop through $fatal, the log decides
./obj_dir/Vtb_cache_top > sim.log 2>&1 || true
cat sim.log
if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation PASSED"
